// ==== project.f ====
logic/stream_cfg_pkg.sv
logic/stream_if_pkg.sv
logic/stream_alloc_ctrl.sv
logic/stream_burst_fsm.sv
logic/stream_beat_counter.sv
logic/stream_data_fifo.sv
logic/stream_prefetch_top.sv
tb/tb_clock_gen.sv
tb/tb_stream_prefetch.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall -Wno-fatal
TOP        ?= tb_stream_prefetch
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_stream_prefetch.sv ====
// Testbench with memory model, random consumer, reference model, checks and timeout
`timescale 1ns/1ps

module tb_stream_prefetch;

        localparam int NUM_CMDS = 20;
        localparam int MAX_LEN  = 70;
        localparam int DEPTH    = stream_cfg_pkg::BUF_DEPTH;
        localparam int STEP     = stream_cfg_pkg::BEAT_BYTES;

        logic                                    axi_aclk;
        logic                                    arst_n;
        logic                                    cmd_valid;
        stream_if_pkg::stream_cmd_t              cmd;
        logic                                    cmd_ready;
        logic                                    ar_valid;
        stream_if_pkg::stream_ar_t               ar;
        logic                                    ar_ready;
        logic                                    r_valid;
        stream_if_pkg::stream_beat_t             r;
        logic                                    out_valid;
        logic [stream_cfg_pkg::DATA_W-1:0]       out_data;
        logic                                    out_ready;
        logic [stream_cfg_pkg::CNT_W-1:0]        space_free;
        logic                                    busy;

        // Reference model state
        stream_if_pkg::stream_cmd_t              cmds [NUM_CMDS];
        stream_if_pkg::stream_ar_t               exp_ar [$];
        logic [stream_cfg_pkg::DATA_W-1:0]       exp_data [$];
        // Bursts accepted by the memory model
        stream_if_pkg::stream_ar_t               mem_q [$];
        int mem_beat       = 0;
        int cmd_idx        = 0;
        int cmd_wait       = 0;
        logic cmd_fire     = 1'b0;
        int issued_beats   = 0;
        int returned_beats = 0;
        int drained_beats  = 0;
        int cur_len        = 0;
        int cur_ret        = 0;
        int stall_left     = 0;
        int total_beats    = 0;
        int cycle_limit    = 0;
        int cycles         = 0;
        int mismatches     = 0;
        int other_errors   = 0;
        int unsigned seed_value;

        tb_clock_gen i_clk (.axi_aclk (axi_aclk));

        stream_prefetch_top i_dut (
                .axi_aclk   (axi_aclk),
                .arst_n     (arst_n),
                .cmd_valid  (cmd_valid),
                .cmd        (cmd),
                .cmd_ready  (cmd_ready),
                .ar_valid   (ar_valid),
                .ar         (ar),
                .ar_ready   (ar_ready),
                .r_valid    (r_valid),
                .r          (r),
                .out_valid  (out_valid),
                .out_data   (out_data),
                .out_ready  (out_ready),
                .space_free (space_free),
                .busy       (busy)
        );

        // ------------------------------
        // Reporting
        // ------------------------------

        task automatic check_value(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
                if (expected !== actual) begin
                        mismatches++;
                        $display("mismatch %s: expected 0x%0h actual 0x%0h at %0t",
                                 name, expected, actual, $time);
                end
        endtask

        task automatic report_error(input string what);
                other_errors++;
                $display("error: %s at %0t", what, $time);
        endtask

        // ------------------------------
        // Reference model
        // ------------------------------

        // Whole command list with its bursts and data order
        task automatic build_model();
                logic [stream_cfg_pkg::ADDR_W-1:0] addr;
                stream_if_pkg::stream_ar_t         burst;
                int                                len;
                int                                left;
                int                                n;
                for (int i = 0; i < NUM_CMDS; i++) begin
                        addr = $urandom;
                        addr = addr - (addr % STEP);
                        len  = 1 + int'($urandom % MAX_LEN);
                        cmds[i].addr  = addr;
                        cmds[i].beats = 16'(len);
                        total_beats += len;
                        // Byte address of every beat
                        for (int b = 0; b < len; b++) begin
                                exp_data.push_back(addr + 32'(b * STEP));
                        end
                        // Full bursts first and the remainder last
                        left = len;
                        while (left > 0) begin
                                n = (left > stream_cfg_pkg::MAX_BURST) ?
                                    stream_cfg_pkg::MAX_BURST : left;
                                burst.addr = addr;
                                burst.len  = 4'(n - 1);
                                exp_ar.push_back(burst);
                                addr = addr + 32'(n * STEP);
                                left -= n;
                        end
                end
                cycle_limit = 40 * total_beats + 200;
        endtask

        // ------------------------------
        // Per-cycle checks on falling edge
        // ------------------------------

        task automatic check_state();
                int pending;
                int reserved;
                // Granted burst still waiting in ISSUE already holds its space
                pending = 0;
                if (ar_valid && exp_ar.size() > 0) begin
                        pending = int'(exp_ar[0].len) + 1;
                end
                reserved = issued_beats + pending - drained_beats;
                if (reserved > DEPTH) begin
                        report_error($sformatf("buffer overcommitted, %0d beats reserved",
                                               reserved));
                end
                check_value("space_free", 64'(DEPTH - reserved), 64'(space_free));
                check_value("busy", 64'(cur_ret < cur_len), 64'(busy));
                // Stored beats show up one cycle after their write
                check_value("out_valid", 64'(returned_beats > drained_beats), 64'(out_valid));
                if (cmd_ready && busy) begin
                        report_error("cmd_ready is high while busy");
                end
                if (ar_valid && exp_ar.size() == 0) begin
                        report_error("burst request issued with no burst left to request");
                end
        endtask

        task automatic drive_inputs();
                // Command held until the handshake and followed by a short random gap
                if (cmd_fire) begin
                        cmd_valid = 1'b0;
                        cmd_idx++;
                        cmd_wait = int'($urandom % 6);
                end else if (!cmd_valid && cmd_idx < NUM_CMDS) begin
                        if (cmd_wait == 0) begin
                                cmd_valid = 1'b1;
                                cmd       = cmds[cmd_idx];
                        end else begin
                                cmd_wait--;
                        end
                end
                ar_ready = ($urandom % 3) != 0;
                // Consumer with long stalls to fill the buffer
                if (stall_left > 0) begin
                        out_ready = 1'b0;
                        stall_left--;
                end else if ($urandom % 48 == 0) begin
                        out_ready  = 1'b0;
                        stall_left = 20 + int'($urandom % 60);
                end else begin
                        out_ready = ($urandom % 4) != 0;
                end
                // Memory returns beats in order with random gaps
                r_valid = 1'b0;
                r       = '0;
                if (mem_q.size() > 0 && ($urandom % 4) != 0) begin
                        r_valid = 1'b1;
                        r.data  = mem_q[0].addr + 32'(mem_beat * STEP);
                        r.last  = (mem_beat == int'(mem_q[0].len));
                        if (r.last) begin
                                void'(mem_q.pop_front());
                                mem_beat = 0;
                        end else begin
                                mem_beat++;
                        end
                end
        endtask

        // Handshakes that take effect on the next rising edge
        task automatic record_handshakes();
                stream_if_pkg::stream_ar_t         burst;
                logic [stream_cfg_pkg::DATA_W-1:0] word;
                if (r_valid) begin
                        cur_ret++;
                        returned_beats++;
                end
                cmd_fire = cmd_valid && cmd_ready;
                if (cmd_fire) begin
                        cur_len = int'(cmd.beats);
                        cur_ret = 0;
                end
                if (ar_valid && ar_ready) begin
                        mem_q.push_back(ar);
                        if (exp_ar.size() == 0) begin
                                report_error("unexpected burst request accepted");
                        end else begin
                                burst = exp_ar.pop_front();
                                check_value("ar_addr", 64'(burst.addr), 64'(ar.addr));
                                check_value("ar_len", 64'(burst.len), 64'(ar.len));
                                issued_beats += int'(burst.len) + 1;
                        end
                end
                if (out_valid && out_ready) begin
                        drained_beats++;
                        if (exp_data.size() == 0) begin
                                report_error("consumer got a beat beyond the expected data");
                        end else begin
                                word = exp_data.pop_front();
                                check_value("out_data", 64'(word), 64'(out_data));
                        end
                end
        endtask

        // ------------------------------
        // Timeout
        // ------------------------------

        always @(posedge axi_aclk) begin
                cycles <= cycles + 1;
                if (cycle_limit > 0 && cycles >= cycle_limit) begin
                        report_error($sformatf("run timed out after %0d cycles", cycles));
                        $display("errors: %0d mismatches, %0d other failures",
                                 mismatches, other_errors);
                        $display("Test FAILED");
                        $finish;
                end
        end

        // ------------------------------
        // Main sequence
        // ------------------------------

        initial begin
                arst_n    = 1'b0;
                cmd_valid = 1'b0;
                cmd       = '0;
                ar_ready  = 1'b0;
                r_valid   = 1'b0;
                r         = '0;
                out_ready = 1'b0;
                seed_value = $urandom(32'hb0ac_74e0);
                build_model();

                repeat (8) @(posedge axi_aclk);
                @(negedge axi_aclk);
                arst_n = 1'b1;
                // Reset values
                check_value("cmd_ready after reset", 64'(1), 64'(cmd_ready));
                check_value("ar_valid after reset", 64'(0), 64'(ar_valid));
                check_value("out_valid after reset", 64'(0), 64'(out_valid));
                check_value("busy after reset", 64'(0), 64'(busy));
                check_value("space_free after reset", 64'(DEPTH), 64'(space_free));

                while (cmd_idx < NUM_CMDS || exp_data.size() > 0) begin
                        @(negedge axi_aclk);
                        check_state();
                        drive_inputs();
                        record_handshakes();
                end

                // Idle tail with all space returned
                repeat (4) begin
                        @(negedge axi_aclk);
                        check_state();
                        drive_inputs();
                        record_handshakes();
                end
                check_value("space_free when idle", 64'(DEPTH), 64'(space_free));
                check_value("cmd_ready when idle", 64'(1), 64'(cmd_ready));
                check_value("busy when idle", 64'(0), 64'(busy));
                if (exp_ar.size() != 0 || mem_q.size() != 0) begin
                        report_error("bursts left over at the end of the run");
                end

                $display("errors: %0d mismatches, %0d other failures",
                         mismatches, other_errors);
                if (mismatches == 0 && other_errors == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock source for axi_aclk with a 4 ns period
`timescale 1ns/1ps

module tb_clock_gen (
        output logic axi_aclk
);

        // Half period of 2 ns
        localparam realtime HALF_PERIOD = 2.0;

        initial begin
                axi_aclk = 1'b0;
        end

        // Free running, stopped only by the end of the run
        always begin
                #(HALF_PERIOD);
                axi_aclk = ~axi_aclk;
        end

endmodule

// ==== logic/stream_prefetch_top.sv ====
// Prefetch read engine top level joining burst FSM, beat counter, space allocator and data FIFO
`timescale 1ns/1ps

module stream_prefetch_top (
        input  logic                              axi_aclk,
        input  logic                              arst_n,

        // Read command
        input  logic                              cmd_valid,
        input  stream_if_pkg::stream_cmd_t        cmd,
        output logic                              cmd_ready,

        // Burst requests to memory
        output logic                              ar_valid,
        output stream_if_pkg::stream_ar_t         ar,
        input  logic                              ar_ready,

        // Returned beats, always accepted
        input  logic                              r_valid,
        input  stream_if_pkg::stream_beat_t       r,

        // Consumer
        output logic                              out_valid,
        output logic [stream_cfg_pkg::DATA_W-1:0] out_data,
        input  logic                              out_ready,

        // Status
        output logic [stream_cfg_pkg::CNT_W-1:0]  space_free,
        output logic                              busy
);

        // ------------------------------
        // Internal wiring
        // ------------------------------

        logic                             alloc_valid;
        logic [4:0]                       alloc_size;
        logic                             alloc_ready;
        logic                             cmd_load;
        logic [stream_cfg_pkg::LEN_W-1:0] cmd_beats;
        logic                             cmd_done;
        // Consumer drain frees one reserved entry
        logic                             drain;

        stream_burst_fsm i_fsm (
                .axi_aclk    (axi_aclk),
                .arst_n      (arst_n),
                .cmd_valid   (cmd_valid),
                .cmd         (cmd),
                .cmd_ready   (cmd_ready),
                .alloc_valid (alloc_valid),
                .alloc_size  (alloc_size),
                .alloc_ready (alloc_ready),
                .ar_valid    (ar_valid),
                .ar          (ar),
                .ar_ready    (ar_ready),
                .cmd_load    (cmd_load),
                .cmd_beats   (cmd_beats),
                .cmd_done    (cmd_done),
                .busy        (busy)
        );

        // Counts down on every returned beat
        stream_beat_counter i_counter (
                .axi_aclk   (axi_aclk),
                .arst_n     (arst_n),
                .load       (cmd_load),
                .load_beats (cmd_beats),
                .beat       (r_valid),
                .done       (cmd_done)
        );

        stream_alloc_ctrl i_alloc (
                .axi_aclk     (axi_aclk),
                .arst_n       (arst_n),
                .alloc_valid  (alloc_valid),
                .alloc_size   (alloc_size),
                .alloc_ready  (alloc_ready),
                .release_beat (drain),
                .space_free   (space_free)
        );

        stream_data_fifo i_fifo (
                .axi_aclk (axi_aclk),
                .arst_n   (arst_n),
                .wr_valid (r_valid),
                .wr_beat  (r),
                .rd_valid (out_valid),
                .rd_data  (out_data),
                .rd_ready (out_ready),
                .drain    (drain)
        );

endmodule

// ==== logic/stream_data_fifo.sv ====
// Storage FIFO for returned beats with a valid/ready consumer port and drain pulse
`timescale 1ns/1ps

module stream_data_fifo (
        input  logic                              axi_aclk,
        input  logic                              arst_n,

        // Write side, no back-pressure
        input  logic                              wr_valid,
        input  stream_if_pkg::stream_beat_t       wr_beat,

        // Consumer side
        output logic                              rd_valid,
        output logic [stream_cfg_pkg::DATA_W-1:0] rd_data,
        input  logic                              rd_ready,

        // Beat handed to the consumer
        output logic                              drain
);

        // ------------------------------
        // Storage and pointers
        // ------------------------------

        // Data only, burst boundaries are of no use downstream
        logic [stream_cfg_pkg::DATA_W-1:0] mem [stream_cfg_pkg::BUF_DEPTH];

        // Extra top bit tells full from empty
        logic [stream_cfg_pkg::CNT_W-1:0] wr_ptr;
        logic [stream_cfg_pkg::CNT_W-1:0] rd_ptr;

        // Entry index without the wrap bit
        logic [stream_cfg_pkg::CNT_W-2:0] wr_idx;
        logic [stream_cfg_pkg::CNT_W-2:0] rd_idx;

        assign wr_idx = wr_ptr[stream_cfg_pkg::CNT_W-2:0];
        assign rd_idx = rd_ptr[stream_cfg_pkg::CNT_W-2:0];

        // ------------------------------
        // Write
        // ------------------------------

        // Space already reserved upstream, overflow cannot happen
        always_ff @(posedge axi_aclk) begin
                if (wr_valid) begin
                        mem[wr_idx] <= wr_beat.data;
                end
        end

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                end else if (wr_valid) begin
                        wr_ptr <= wr_ptr + 1'b1;
                end
        end

        // ------------------------------
        // Read
        // ------------------------------

        // Written beat shows up the next cycle
        assign rd_valid = (wr_ptr != rd_ptr);
        assign rd_data  = mem[rd_idx];
        assign drain    = rd_valid && rd_ready;

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        rd_ptr <= '0;
                end else if (drain) begin
                        rd_ptr <= rd_ptr + 1'b1;
                end
        end

endmodule

// ==== logic/stream_beat_counter.sv ====
// Down-counter of beats still to return for the current command, with completion flag
`timescale 1ns/1ps

module stream_beat_counter (
        input  logic                             axi_aclk,
        input  logic                             arst_n,

        // Command length, loaded on acceptance
        input  logic                             load,
        input  logic [stream_cfg_pkg::LEN_W-1:0] load_beats,

        // One per beat returned by memory
        input  logic                             beat,

        // Nothing outstanding
        output logic                             done
);

        // ------------------------------
        // Outstanding beat count
        // ------------------------------

        logic [stream_cfg_pkg::LEN_W-1:0] count;

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        count <= '0;
                end else if (load) begin
                        // No beats in flight when a new command loads
                        count <= load_beats;
                end else if (beat && (count != '0)) begin
                        count <= count - 1'b1;
                end
        end

        // High the cycle after the final beat
        assign done = (count == '0);

endmodule

// ==== logic/stream_burst_fsm.sv ====
// FSM that splits a read command into bursts, reserves space and issues burst requests
`timescale 1ns/1ps

module stream_burst_fsm (
        input  logic                             axi_aclk,
        input  logic                             arst_n,

        // Command in
        input  logic                             cmd_valid,
        input  stream_if_pkg::stream_cmd_t       cmd,
        output logic                             cmd_ready,

        // Space reservation
        output logic                             alloc_valid,
        output logic [4:0]                       alloc_size,
        input  logic                             alloc_ready,

        // Burst request out
        output logic                             ar_valid,
        output stream_if_pkg::stream_ar_t        ar,
        input  logic                             ar_ready,

        // Beat counter load and completion
        output logic                             cmd_load,
        output logic [stream_cfg_pkg::LEN_W-1:0] cmd_beats,
        input  logic                             cmd_done,

        output logic                             busy
);

        typedef enum logic [1:0] {
                IDLE,
                ALLOC,
                ISSUE,
                DRAIN
        } state_t;

        state_t state;

        // Address of the next burst and beats not yet requested
        logic [stream_cfg_pkg::ADDR_W-1:0] next_addr;
        logic [stream_cfg_pkg::LEN_W-1:0]  remain;

        // Burst held stable through ar_ready stalls
        stream_if_pkg::stream_ar_t ar_q;

        // ------------------------------
        // Burst sizing
        // ------------------------------

        logic [4:0]                        burst_size;
        logic [4:0]                        burst_len_m1;
        logic [stream_cfg_pkg::LEN_W-1:0]  burst_beats;
        logic [stream_cfg_pkg::ADDR_W-1:0] burst_bytes;

        // Smaller of MAX_BURST and what is left
        assign burst_size = (remain >= stream_cfg_pkg::MAX_BURST[stream_cfg_pkg::LEN_W-1:0])
                            ? stream_cfg_pkg::MAX_BURST[4:0] : remain[4:0];

        assign burst_len_m1 = burst_size - 5'd1;
        assign burst_beats  = {{(stream_cfg_pkg::LEN_W-5){1'b0}}, burst_size};

        // Byte span of the burst
        assign burst_bytes = {{(stream_cfg_pkg::ADDR_W-5){1'b0}}, burst_size}
                             * stream_cfg_pkg::BEAT_BYTES[stream_cfg_pkg::ADDR_W-1:0];

        // ------------------------------
        // Outputs
        // ------------------------------

        assign cmd_ready   = (state == IDLE);
        assign cmd_load    = cmd_valid && cmd_ready;
        assign cmd_beats   = cmd.beats;

        assign alloc_valid = (state == ALLOC);
        assign alloc_size  = burst_size;

        assign ar_valid    = (state == ISSUE);
        assign ar          = ar_q;

        // Drops together with cmd_done, a cycle ahead of the IDLE return
        assign busy = (state != IDLE) && !((state == DRAIN) && cmd_done);

        // ------------------------------
        // State machine
        // ------------------------------

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        state     <= IDLE;
                        next_addr <= '0;
                        remain    <= '0;
                end else begin
                        case (state)
                                IDLE: begin
                                        if (cmd_valid) begin
                                                next_addr <= cmd.addr;
                                                remain    <= cmd.beats;
                                                state     <= ALLOC;
                                        end
                                end
                                // Wait for room for the whole burst
                                ALLOC: begin
                                        if (alloc_ready) begin
                                                next_addr <= next_addr + burst_bytes;
                                                remain    <= remain - burst_beats;
                                                state     <= ISSUE;
                                        end
                                end
                                ISSUE: begin
                                        if (ar_ready) begin
                                                // Last burst sent, wait for its beats
                                                state <= (remain == '0) ? DRAIN : ALLOC;
                                        end
                                end
                                DRAIN: begin
                                        if (cmd_done) begin
                                                state <= IDLE;
                                        end
                                end
                                default: state <= IDLE;
                        endcase
                end
        end

        // Burst payload, latched on the grant
        always_ff @(posedge axi_aclk) begin
                if ((state == ALLOC) && alloc_ready) begin
                        ar_q.addr <= next_addr;
                        ar_q.len  <= burst_len_m1[3:0];
                end
        end

endmodule

// ==== logic/stream_alloc_ctrl.sv ====
// Virtual FIFO that reserves variable-size buffer space and frees one entry per drained beat
`timescale 1ns/1ps

module stream_alloc_ctrl (
        input  logic                             axi_aclk,
        input  logic                             arst_n,

        // Reservation request, one burst at a time
        input  logic                             alloc_valid,
        input  logic [4:0]                       alloc_size,
        output logic                             alloc_ready,

        // One pulse per beat taken by the consumer
        input  logic                             release_beat,

        // Unreserved entries
        output logic [stream_cfg_pkg::CNT_W-1:0] space_free
);

        // ------------------------------
        // Pointers and next values
        // ------------------------------

        // Pointers only, no data held here
        logic [stream_cfg_pkg::CNT_W-1:0] alloc_ptr;
        logic [stream_cfg_pkg::CNT_W-1:0] rel_ptr;
        logic [stream_cfg_pkg::CNT_W-1:0] alloc_ptr_nxt;
        logic [stream_cfg_pkg::CNT_W-1:0] rel_ptr_nxt;

        // Request size widened to pointer width
        logic [stream_cfg_pkg::CNT_W-1:0] size_ext;

        // Entries reserved after this cycle's updates
        logic [stream_cfg_pkg::CNT_W-1:0] used_nxt;

        logic grant;

        assign size_ext = {{(stream_cfg_pkg::CNT_W-5){1'b0}}, alloc_size};

        // Whole burst must fit, not just one free slot
        assign alloc_ready = (space_free >= size_ext);
        assign grant       = alloc_valid && alloc_ready;

        // Allocation side jumps by the burst size
        assign alloc_ptr_nxt = grant ? alloc_ptr + size_ext : alloc_ptr;

        // Release side steps by one
        assign rel_ptr_nxt = release_beat ? rel_ptr + 1'b1 : rel_ptr;

        // Wrapping difference, pointers carry one extra bit
        assign used_nxt = alloc_ptr_nxt - rel_ptr_nxt;

        // ------------------------------
        // State registers
        // ------------------------------

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        alloc_ptr  <= '0;
                        rel_ptr    <= '0;
                        // Whole buffer free out of reset
                        space_free <= stream_cfg_pkg::BUF_DEPTH[stream_cfg_pkg::CNT_W-1:0];
                end else begin
                        alloc_ptr  <= alloc_ptr_nxt;
                        rel_ptr    <= rel_ptr_nxt;
                        // Grant and release in one cycle both counted
                        space_free <= stream_cfg_pkg::BUF_DEPTH[stream_cfg_pkg::CNT_W-1:0]
                                      - used_nxt;
                end
        end

endmodule

// ==== logic/stream_if_pkg.sv ====
// Packed structs for the read command, the burst request and the returned beat
package stream_if_pkg;

        // ------------------------------
        // Command from the requester
        // ------------------------------

        // Start address and length, beats is never zero
        typedef struct packed {
                logic [stream_cfg_pkg::ADDR_W-1:0] addr;
                logic [stream_cfg_pkg::LEN_W-1:0]  beats;
        } stream_cmd_t;

        // ------------------------------
        // Burst request to memory
        // ------------------------------

        // Burst start address and length minus one
        typedef struct packed {
                logic [stream_cfg_pkg::ADDR_W-1:0] addr;
                logic [3:0]                        len;
        } stream_ar_t;

        // ------------------------------
        // Beat returned by memory
        // ------------------------------

        // Payload plus end-of-burst marker
        typedef struct packed {
                logic [stream_cfg_pkg::DATA_W-1:0] data;
                logic                              last;
        } stream_beat_t;

endpackage

// ==== logic/stream_cfg_pkg.sv ====
// Sizes and limits for the prefetch buffer, memory bursts, addresses and data
package stream_cfg_pkg;

        // ------------------------------
        // Buffer sizing
        // ------------------------------

        // Entries in the data FIFO, also the reservation limit
        localparam int BUF_DEPTH = 32;

        // Occupancy and space counts, wide enough to hold BUF_DEPTH itself
        localparam int CNT_W = $clog2(BUF_DEPTH) + 1;

        // ------------------------------
        // Burst limits
        // ------------------------------

        // Longest burst the memory side accepts, in beats
        localparam int MAX_BURST = 16;

        // ------------------------------
        // Address and data
        // ------------------------------

        // Byte address
        localparam int ADDR_W = 32;
        // One beat of payload
        localparam int DATA_W = 32;
        // Command length, counted in beats
        localparam int LEN_W = 16;
        // Address step per beat
        localparam int BEAT_BYTES = 4;

endpackage
